//--- hdl/hostbus_defines.svh
// sizes shared by the host bus slave, include wherever a width is needed
// the word is HB_WORD_BEATS bytes, sent most significant byte first
`ifndef HOSTBUS_DEFINES_SVH
`define HOSTBUS_DEFINES_SVH

// host side
`define HB_BUS_WIDTH 8 // byte lane of the gpio bus
`define HB_WORD_BEATS 2 // data beats per word

// memory side
`define HB_WORD_WIDTH 16 // must equal HB_BUS_WIDTH * HB_WORD_BEATS
`define HB_ADDR_WIDTH 8 // 256 words

// command flow control between assembler and memory stage
`define HB_CMD_CREDITS 2 // fifo depth, also the credit count after reset

// framing error counter, saturates at all ones
`define HB_FAULT_WIDTH 8

`endif

//--- hdl/hostbus_pkg.sv
// host side types, the beat kinds from the front end and the assembler phases
// referenced as hostbus_pkg::name
`default_nettype none

package hostbus_pkg;

	// what the host strobed, decoded from read and register_select
	typedef enum logic [1:0] {
		BEAT_ADDR  = 2'd0, // register_select low
		BEAT_WDATA = 2'd1, // data beat with read low
		BEAT_RDATA = 2'd2 // data beat with read high
	} beat_kind_t;

	// where the assembler stands inside a word
	typedef enum logic [1:0] {
		PH_IDLE      = 2'd0, // on a word boundary
		PH_WRITING   = 2'd1, // some bytes of a write word taken
		PH_READING   = 2'd2, // some bytes of the held word returned
		PH_WAIT_WORD = 2'd3 // read beat parked until the word arrives
	} asm_phase_t;

endpackage

`default_nettype wire

//--- hdl/mem_pkg.sv
// memory side types, the command opcodes and the access engine states
// referenced as mem_pkg::name
`default_nettype none

package mem_pkg;

	// command from the assembler to the memory stage
	typedef enum logic {
		OP_READ  = 1'b0, // fetch word at cmd_addr
		OP_WRITE = 1'b1 // store cmd_wdata, echo it back
	} mem_op_t;

	// two cycle access engine
	typedef enum logic {
		MS_IDLE   = 1'b0, // free to pop the fifo
		MS_ACCESS = 1'b1 // ram cycle for the popped command
	} mem_state_t;

endpackage

`default_nettype wire

//--- hdl/hostbus_frontend.sv
// host bus front end, synchronizes the strobes and turns each enable edge into a beat
// answers with ack and drives the read byte while ack is up on a read
`timescale 1ns/100ps
`default_nettype none
`include "hostbus_defines.svh"

module hostbus_frontend (
	input  wire logic                     clock50,
	input  wire logic                     reset,
	// host side
	input  wire logic                     enable,
	input  wire logic                     read,
	input  wire logic                     register_select,
	input  wire logic [`HB_BUS_WIDTH-1:0] bus_in,
	// from the assembler
	input  wire logic                     beat_done,
	input  wire logic [`HB_BUS_WIDTH-1:0] rd_byte,
	// to the assembler
	output logic                          beat_valid,
	output hostbus_pkg::beat_kind_t       beat_kind,
	output logic [`HB_BUS_WIDTH-1:0]      beat_data,
	// back to the host
	output logic                          ack,
	output logic [`HB_BUS_WIDTH-1:0]      bus_out,
	output logic                          bus_oe
);

	// strobes packed as {enable, read, register_select}
	logic [2:0]               strobe_meta;
	logic [2:0]               strobe_sync;
	logic                     enable_d; // edge detect flop
	logic                     enable_rise;
	logic                     ack_hold;
	logic                     beat_is_read; // kind of the current beat
	logic [`HB_BUS_WIDTH-1:0] rd_byte_q;

	assign enable_rise = strobe_sync[2] & ~enable_d;

	// two flop synchronizer for all three host strobes
	always_ff @(posedge clock50) begin
		if (reset) begin
			strobe_meta <= '0;
			strobe_sync <= '0;
			enable_d <= 1'b0;
		end else begin
			strobe_meta <= {enable, read, register_select};
			strobe_sync <= strobe_meta;
			enable_d <= strobe_sync[2];
		end
	end

	// one beat per rising edge of enable
	always_ff @(posedge clock50) begin
		if (reset) begin
			beat_valid <= 1'b0;
			beat_is_read <= 1'b0;
		end else begin
			beat_valid <= enable_rise;
			if (enable_rise) begin
				beat_is_read <= strobe_sync[1] & strobe_sync[0];
			end
		end
	end

	// bus_in has been stable since before enable went up, so it is
	// sampled directly here three cycles later
	always_ff @(posedge clock50) begin
		if (enable_rise) begin
			beat_data <= bus_in;
			if (!strobe_sync[0]) begin
				beat_kind <= hostbus_pkg::BEAT_ADDR; // read is ignored here
			end else if (strobe_sync[1]) begin
				beat_kind <= hostbus_pkg::BEAT_RDATA;
			end else begin
				beat_kind <= hostbus_pkg::BEAT_WDATA;
			end
		end
	end

	// ack is held from the cycle after beat_done until enable drops
	always_ff @(posedge clock50) begin
		if (reset) begin
			ack_hold <= 1'b0;
		end else if (!strobe_sync[2]) begin
			ack_hold <= 1'b0;
		end else if (beat_done) begin
			ack_hold <= 1'b1;
		end
	end

	// read byte latched with beat_done, held for the whole ack
	always_ff @(posedge clock50) begin
		if (beat_done) begin
			rd_byte_q <= rd_byte;
		end
	end

	// gating with the synced enable drops ack two cycles after the host does
	assign ack = ack_hold & strobe_sync[2];
	assign bus_oe = ack & beat_is_read; // drive only on a read beat
	assign bus_out = rd_byte_q;

endmodule

`default_nettype wire

//--- hdl/word_assembler.sv
// word assembler, collects write bytes into words and hands read bytes out of the held word
// issues memory commands against a credit count, counts framing errors
`timescale 1ns/100ps
`default_nettype none
`include "hostbus_defines.svh"

module word_assembler (
	input  wire logic                      clock50,
	input  wire logic                      reset,
	input  wire logic                      beat_valid,
	input  wire hostbus_pkg::beat_kind_t   beat_kind,
	input  wire logic [`HB_BUS_WIDTH-1:0]  beat_data,
	input  wire logic                      credit_return,
	input  wire logic                      rd_word_valid,
	input  wire logic [`HB_WORD_WIDTH-1:0] rd_word,
	output logic                           beat_done,
	output logic [`HB_BUS_WIDTH-1:0]       rd_byte,
	output logic                           cmd_valid,
	output mem_pkg::mem_op_t               cmd_op,
	output logic [`HB_ADDR_WIDTH-1:0]      cmd_addr,
	output logic [`HB_WORD_WIDTH-1:0]      cmd_wdata,
	output logic [`HB_FAULT_WIDTH-1:0]     fault_count
);

	localparam int IDX_W = $clog2(`HB_WORD_BEATS);
	localparam int CRED_W = $clog2(`HB_CMD_CREDITS + 1);
	localparam int RSP_W = $clog2(`HB_CMD_CREDITS + 2); // fifo plus one in flight

	hostbus_pkg::asm_phase_t        phase;
	logic [IDX_W-1:0]               byte_idx; // 0 is the most significant byte
	logic [CRED_W-1:0]              credit_count;
	logic [RSP_W-1:0]               rsp_pending; // commands without a word back yet
	logic                           prefetch_pending;
	logic                           wr_stall; // last write byte waiting for a credit
	logic                           held_valid;
	logic [`HB_ADDR_WIDTH-1:0]      addr;
	logic [`HB_WORD_WIDTH-1:0]      wr_word;
	logic [`HB_WORD_WIDTH-1:0]      wr_word_next;
	logic [`HB_WORD_WIDTH-1:0]      held_word;
	int                             byte_shift;
	logic                           addr_beat;
	logic                           wdata_beat;
	logic                           rd_beat;
	logic                           last_byte;
	logic                           credit_avail;
	logic                           issue_prefetch;
	logic                           issue_write;
	logic                           issue_any;
	logic                           read_serve;

	assign addr_beat = beat_valid && (beat_kind == hostbus_pkg::BEAT_ADDR);
	assign wdata_beat = beat_valid && (beat_kind == hostbus_pkg::BEAT_WDATA);
	assign rd_beat = beat_valid && (beat_kind == hostbus_pkg::BEAT_RDATA);
	assign last_byte = (byte_idx == IDX_W'(`HB_WORD_BEATS - 1));
	assign byte_shift = (`HB_WORD_BEATS - 1 - int'(byte_idx)) * `HB_BUS_WIDTH;
	assign credit_avail = (credit_count != '0);

	// the prefetch goes first so commands leave in host order
	assign issue_prefetch = prefetch_pending && credit_avail;
	assign issue_write = !prefetch_pending && credit_avail && (wr_stall || (wdata_beat && last_byte));
	assign issue_any = issue_prefetch || issue_write;
	assign read_serve = held_valid && (rd_beat || phase == hostbus_pkg::PH_WAIT_WORD);

	always_comb begin
		wr_word_next = wr_word;
		wr_word_next[byte_shift +: `HB_BUS_WIDTH] = beat_data;
	end

	always_ff @(posedge clock50) begin
		if (reset) begin
			phase <= hostbus_pkg::PH_IDLE;
			byte_idx <= '0;
			credit_count <= CRED_W'(`HB_CMD_CREDITS);
			rsp_pending <= '0;
			prefetch_pending <= 1'b0;
			wr_stall <= 1'b0;
			held_valid <= 1'b0;
			fault_count <= '0;
			beat_done <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			beat_done <= 1'b0;
			cmd_valid <= issue_any;
			credit_count <= credit_count - CRED_W'(issue_any) + CRED_W'(credit_return);
			rsp_pending <= rsp_pending + RSP_W'(issue_any) - RSP_W'(rd_word_valid);
			// held word is good only once the newest command has answered
			if (issue_any || addr_beat) begin
				held_valid <= 1'b0;
			end else if (rd_word_valid && rsp_pending == RSP_W'(1) && !prefetch_pending) begin
				held_valid <= 1'b1;
			end
			if (issue_prefetch) begin
				prefetch_pending <= 1'b0;
			end
			if (addr_beat) begin
				prefetch_pending <= 1'b1; // wins over a stale prefetch leaving now
				if (byte_idx != '0 && fault_count != '1) begin
					fault_count <= fault_count + 1'b1; // word abandoned
				end
				byte_idx <= '0;
				phase <= hostbus_pkg::PH_IDLE;
				beat_done <= 1'b1;
			end else if (wdata_beat && !last_byte) begin
				byte_idx <= byte_idx + 1'b1;
				phase <= hostbus_pkg::PH_WRITING;
				beat_done <= 1'b1;
			end else if (wdata_beat || wr_stall) begin
				if (issue_write) begin
					wr_stall <= 1'b0;
					byte_idx <= '0;
					phase <= hostbus_pkg::PH_IDLE;
					beat_done <= 1'b1;
				end else begin
					wr_stall <= 1'b1; // ack waits for memory
					phase <= hostbus_pkg::PH_WRITING;
				end
			end else if (read_serve) begin
				byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
				phase <= last_byte ? hostbus_pkg::PH_IDLE : hostbus_pkg::PH_READING;
				beat_done <= 1'b1;
			end else if (rd_beat) begin
				phase <= hostbus_pkg::PH_WAIT_WORD;
			end
		end
	end

	always_ff @(posedge clock50) begin
		if (addr_beat) begin
			addr <= beat_data[`HB_ADDR_WIDTH-1:0];
		end
		if (wdata_beat) begin
			wr_word <= wr_word_next;
		end
		if (issue_any) begin
			cmd_op <= issue_prefetch ? mem_pkg::OP_READ : mem_pkg::OP_WRITE;
			cmd_addr <= addr;
			cmd_wdata <= wr_stall ? wr_word : wr_word_next;
		end
		if (rd_word_valid) begin
			held_word <= rd_word; // read data or write echo
		end
		if (read_serve) begin
			rd_byte <= held_word[byte_shift +: `HB_BUS_WIDTH];
		end
	end

endmodule

`default_nettype wire

//--- hdl/word_memory.sv
// memory stage, a small command fifo in front of a 256 x 16 ram
// pops one command every two cycles and answers each with a word
`timescale 1ns/100ps
`default_nettype none
`include "hostbus_defines.svh"

module word_memory (
	input  wire logic                      clock50,
	input  wire logic                      reset,
	input  wire logic                      cmd_valid,
	input  wire mem_pkg::mem_op_t          cmd_op,
	input  wire logic [`HB_ADDR_WIDTH-1:0] cmd_addr,
	input  wire logic [`HB_WORD_WIDTH-1:0] cmd_wdata,
	output logic                           credit_return,
	output logic                           rd_word_valid,
	output logic [`HB_WORD_WIDTH-1:0]      rd_word
);

	localparam int PTR_W = $clog2(`HB_CMD_CREDITS);
	localparam int CNT_W = $clog2(`HB_CMD_CREDITS + 1);

	mem_pkg::mem_op_t          fifo_op [`HB_CMD_CREDITS];
	logic [`HB_ADDR_WIDTH-1:0] fifo_addr [`HB_CMD_CREDITS];
	logic [`HB_WORD_WIDTH-1:0] fifo_wdata [`HB_CMD_CREDITS];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [CNT_W-1:0]          fifo_count;
	mem_pkg::mem_state_t       state;
	mem_pkg::mem_op_t          cur_op;
	logic [`HB_ADDR_WIDTH-1:0] cur_addr;
	logic [`HB_WORD_WIDTH-1:0] cur_wdata;
	logic [`HB_WORD_WIDTH-1:0] ram [1 << `HB_ADDR_WIDTH];
	logic [`HB_WORD_WIDTH-1:0] ram_q;
	logic                      access_done;
	logic                      pop;

	// sender owns the credits, so a push never finds the fifo full
	assign pop = (state == mem_pkg::MS_IDLE) && (fifo_count != '0);

	always_ff @(posedge clock50) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
			state <= mem_pkg::MS_IDLE;
			credit_return <= 1'b0;
			access_done <= 1'b0;
			rd_word_valid <= 1'b0;
		end else begin
			credit_return <= pop; // slot freed as the command leaves
			access_done <= (state == mem_pkg::MS_ACCESS);
			rd_word_valid <= access_done;
			if (cmd_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			fifo_count <= fifo_count + CNT_W'(cmd_valid) - CNT_W'(pop);
			case (state)
				mem_pkg::MS_IDLE: if (pop) state <= mem_pkg::MS_ACCESS;
				mem_pkg::MS_ACCESS: state <= mem_pkg::MS_IDLE;
				default: state <= mem_pkg::MS_IDLE;
			endcase
		end
	end

	// fifo storage and the popped command
	always_ff @(posedge clock50) begin
		if (cmd_valid) begin
			fifo_op[wr_ptr] <= cmd_op;
			fifo_addr[wr_ptr] <= cmd_addr;
			fifo_wdata[wr_ptr] <= cmd_wdata;
		end
		if (pop) begin
			cur_op <= fifo_op[rd_ptr];
			cur_addr <= fifo_addr[rd_ptr];
			cur_wdata <= fifo_wdata[rd_ptr];
		end
		// cur_* still holds the answered command even if a new pop lands now
		if (access_done) begin
			rd_word <= (cur_op == mem_pkg::OP_WRITE) ? cur_wdata : ram_q;
		end
	end

	// single port ram, registered read
	always_ff @(posedge clock50) begin
		if (state == mem_pkg::MS_ACCESS) begin
			if (cur_op == mem_pkg::OP_WRITE) begin
				ram[cur_addr] <= cur_wdata;
			end
			ram_q <= ram[cur_addr];
		end
	end

endmodule

`default_nettype wire

//--- hdl/hostbus_top.sv
// host bus slave top, front end into word assembler into memory stage
// bus is split into in, out and output enable, a pad buffer goes outside
`timescale 1ns/100ps
`default_nettype none
`include "hostbus_defines.svh"

module hostbus_top (
	input  wire logic                     clock50,
	input  wire logic                     reset,
	input  wire logic                     enable, // level strobe from the host
	input  wire logic                     read, // 1 read, 0 write
	input  wire logic                     register_select, // 1 data, 0 address
	input  wire logic [`HB_BUS_WIDTH-1:0] bus_in,
	output logic                          ack,
	output logic [`HB_BUS_WIDTH-1:0]      bus_out,
	output logic                          bus_oe,
	output logic [`HB_FAULT_WIDTH-1:0]    fault_count
);

	// beats between front end and assembler
	logic                      beat_valid;
	hostbus_pkg::beat_kind_t   beat_kind;
	logic [`HB_BUS_WIDTH-1:0]  beat_data;
	logic                      beat_done;
	logic [`HB_BUS_WIDTH-1:0]  rd_byte;

	// commands and results between assembler and memory
	logic                      cmd_valid;
	mem_pkg::mem_op_t          cmd_op;
	logic [`HB_ADDR_WIDTH-1:0] cmd_addr;
	logic [`HB_WORD_WIDTH-1:0] cmd_wdata;
	logic                      credit_return;
	logic                      rd_word_valid;
	logic [`HB_WORD_WIDTH-1:0] rd_word;

	hostbus_frontend frontend_i (
		.clock50(clock50), .reset(reset),
		.enable(enable), .read(read), .register_select(register_select), .bus_in(bus_in),
		.beat_done(beat_done), .rd_byte(rd_byte),
		.beat_valid(beat_valid), .beat_kind(beat_kind), .beat_data(beat_data),
		.ack(ack), .bus_out(bus_out), .bus_oe(bus_oe)
	);

	word_assembler assembler_i (
		.clock50(clock50), .reset(reset),
		.beat_valid(beat_valid), .beat_kind(beat_kind), .beat_data(beat_data),
		.credit_return(credit_return), .rd_word_valid(rd_word_valid), .rd_word(rd_word),
		.beat_done(beat_done), .rd_byte(rd_byte),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
		.fault_count(fault_count)
	);

	word_memory memory_i (
		.clock50(clock50), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
		.credit_return(credit_return), .rd_word_valid(rd_word_valid), .rd_word(rd_word)
	);

endmodule

`default_nettype wire

//--- bench/hostbus_assert.sv
// protocol checks bound into every instance of the word assembler
// covers credit bookkeeping, the beat handshake and the framing error count
`timescale 1ns/100ps
`default_nettype none
`include "hostbus_defines.svh"

module hostbus_assert (
	input wire logic                                    clock50,
	input wire logic                                    reset,
	input wire logic                                    beat_valid,
	input wire hostbus_pkg::beat_kind_t                 beat_kind,
	input wire logic                                    beat_done,
	input wire logic                                    cmd_valid,
	input wire logic                                    credit_return,
	input wire logic [$clog2(`HB_CMD_CREDITS + 1)-1:0] credit_count,
	input wire logic [`HB_FAULT_WIDTH-1:0]              fault_count,
	input wire hostbus_pkg::asm_phase_t                 phase
);

	localparam int FLIGHT_W = $clog2(`HB_CMD_CREDITS + 2);

	logic                beat_open; // beat taken and not yet answered
	logic [FLIGHT_W-1:0] in_flight; // commands sent whose credit is still out

	always_ff @(posedge clock50) begin
		if (reset) begin
			beat_open <= 1'b0;
			in_flight <= '0;
		end else begin
			if (beat_valid) begin
				beat_open <= 1'b1;
			end else if (beat_done) begin
				beat_open <= 1'b0;
			end
			in_flight <= in_flight + FLIGHT_W'(cmd_valid) - FLIGHT_W'(credit_return);
		end
	end

	credit_limit: assert property (@(posedge clock50) disable iff (reset)
		credit_count <= `HB_CMD_CREDITS)
		else $error("credit count above the command fifo depth");

	// a command needs a free fifo slot on the memory side
	credit_spent: assert property (@(posedge clock50) disable iff (reset)
		cmd_valid |-> (in_flight < `HB_CMD_CREDITS))
		else $error("command issued with no credit left");

	done_needs_beat: assert property (@(posedge clock50) disable iff (reset)
		beat_done |-> beat_open)
		else $error("beat_done without a pending beat");

	// the count moves only when an address beat cuts a word short
	fault_on_abandon: assert property (@(posedge clock50) disable iff (reset)
		(fault_count != $past(fault_count)) |->
			$past(beat_valid && beat_kind == hostbus_pkg::BEAT_ADDR
				&& phase != hostbus_pkg::PH_IDLE))
		else $error("fault count changed without an interrupted word");

endmodule

bind word_assembler hostbus_assert assert_i (
	.clock50(clock50), .reset(reset), .beat_valid(beat_valid), .beat_kind(beat_kind),
	.beat_done(beat_done), .cmd_valid(cmd_valid), .credit_return(credit_return),
	.credit_count(credit_count), .fault_count(fault_count), .phase(phase)
);

`default_nettype wire

//--- bench/hostbus_tb.sv
// testbench for the host bus slave that drives beats the way a gpio host would
// and checks every read byte against a model of the written words
`timescale 1ns/100ps
`default_nettype none
`include "hostbus_defines.svh"

module hostbus_tb;

	logic                       clock50;
	logic                       reset;
	logic                       enable;
	logic                       read;
	logic                       register_select;
	logic [`HB_BUS_WIDTH-1:0]   bus_in;
	logic                       ack;
	logic [`HB_BUS_WIDTH-1:0]   bus_out;
	logic                       bus_oe;
	logic [`HB_FAULT_WIDTH-1:0] fault_count;
	logic [`HB_FAULT_WIDTH-1:0] faults_expected; // framing errors caused so far
	logic [`HB_WORD_WIDTH-1:0]  model [1 << `HB_ADDR_WIDTH]; // last word per address
	logic [`HB_ADDR_WIDTH-1:0]  addr_list [$];
	logic [`HB_ADDR_WIDTH-1:0]  addr;
	logic [`HB_BUS_WIDTH-1:0]   seen;

	hostbus_top dut_i (
		.clock50(clock50), .reset(reset), .enable(enable), .read(read),
		.register_select(register_select), .bus_in(bus_in), .ack(ack),
		.bus_out(bus_out), .bus_oe(bus_oe), .fault_count(fault_count)
	);

	initial begin
		clock50 = 1'b0;
		forever #4 clock50 = ~clock50;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] want);
		assert (got == want)
		else stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
	endtask

	// polled just after each edge where outputs have settled
	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (ack !== level) begin
			if (cycles == 200) begin
				stop_run($sformatf("timeout, ack never went to %0d", level));
			end
			@(posedge clock50);
			#1;
			cycles++;
		end
	endtask

	// one host beat with enable dropped as soon as ack is seen
	task automatic bus_beat(input logic is_read, input logic is_data,
			input logic [`HB_BUS_WIDTH-1:0] data, output logic [`HB_BUS_WIDTH-1:0] got);
		@(posedge clock50);
		#1;
		read = is_read;
		register_select = is_data;
		bus_in = data; // stable a cycle before enable
		@(posedge clock50);
		#1;
		enable = 1'b1;
		wait_ack(1'b1);
		got = bus_out;
		check_value("bus_oe", 16'(bus_oe), 16'(is_read && is_data));
		enable = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic write_word(input logic [`HB_ADDR_WIDTH-1:0] a,
			input logic [`HB_WORD_WIDTH-1:0] w);
		logic [`HB_BUS_WIDTH-1:0] unused_byte;
		bus_beat(1'b0, 1'b0, a, unused_byte);
		for (int i = `HB_WORD_BEATS - 1; i >= 0; i--) begin
			bus_beat(1'b0, 1'b1, w[i*`HB_BUS_WIDTH +: `HB_BUS_WIDTH], unused_byte); // msb first
		end
		model[a] = w;
	endtask

	// read beats that take whatever word the slave holds
	task automatic read_bytes(input logic [`HB_WORD_WIDTH-1:0] want);
		logic [`HB_BUS_WIDTH-1:0] got;
		for (int i = `HB_WORD_BEATS - 1; i >= 0; i--) begin
			bus_beat(1'b1, 1'b1, '0, got);
			check_value("bus_out", 16'(got), 16'(want[i*`HB_BUS_WIDTH +: `HB_BUS_WIDTH]));
		end
	endtask

	task automatic read_word(input logic [`HB_ADDR_WIDTH-1:0] a);
		logic [`HB_BUS_WIDTH-1:0] unused_byte;
		bus_beat(1'b0, 1'b0, a, unused_byte);
		read_bytes(model[a]);
	endtask

	// output enable only while a read data beat is acknowledged
	always @(negedge clock50) begin
		if (!reset && bus_oe && !(ack && read && register_select)) begin
			stop_run("bus_oe was high outside an acknowledged read beat");
		end
	end

	initial begin
		void'($urandom(50));
		reset = 1'b1;
		enable = 1'b0;
		read = 1'b0;
		register_select = 1'b0;
		bus_in = '0;
		faults_expected = '0;
		repeat (2) @(posedge clock50);
		#1;
		reset = 1'b0;
		check_value("ack", 16'(ack), 16'h0);
		check_value("bus_oe", 16'(bus_oe), 16'h0);
		check_value("fault_count", 16'(fault_count), 16'h0);
		write_word(8'h5a, 16'hbeef);
		read_bytes(16'hbeef); // from the write echo
		read_word(8'h5a);
		// scattered writes read back in reverse order
		repeat (24) begin
			addr = `HB_ADDR_WIDTH'($urandom);
			write_word(addr, `HB_WORD_WIDTH'($urandom));
			addr_list.push_back(addr);
		end
		while (addr_list.size() != 0) begin
			read_word(addr_list.pop_back());
		end
		// back to back writes with the shortest enable pulses
		for (int i = 0; i < 16; i++) begin
			write_word(`HB_ADDR_WIDTH'(8'hc0 + i), `HB_WORD_WIDTH'($urandom));
		end
		for (int i = 0; i < 16; i++) begin
			read_word(`HB_ADDR_WIDTH'(8'hc0 + i));
		end
		// address beat in the middle of a word
		check_value("fault_count", 16'(fault_count), 16'(faults_expected));
		bus_beat(1'b0, 1'b0, 8'h5a, seen);
		bus_beat(1'b0, 1'b1, 8'h11, seen);
		read_word(8'h5a); // abandons the half written word
		faults_expected = faults_expected + 1'b1;
		check_value("fault_count", 16'(fault_count), 16'(faults_expected));
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/hostbus_pkg.sv
hdl/mem_pkg.sv
hdl/hostbus_frontend.sv
hdl/word_assembler.sv
hdl/word_memory.sv
hdl/hostbus_top.sv
bench/hostbus_assert.sv
bench/hostbus_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then decide on the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module hostbus_tb -Mdir obj_dir &&
./obj_dir/Vhostbus_tb 2>&1 | tee sim.log
grep -qs "Testbench passed" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
